// File: project.f
src/fe_pkg.sv
src/if1_packet_reg.sv
src/pre_decoder.sv
src/branch_target.sv
src/priv_fence.sv
src/predecode_top.sv
verif/tb_predecode.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_predecode -Mdir obj_dir -f project.f

out=$(./obj_dir/Vtb_predecode)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

// File: src/branch_target.sv
`timescale 1ns/1ps

module branch_target (
    input  logic [fe_pkg::pc_w-1:0] pc,
    input  fe_pkg::insn_u           inst0,
    input  fe_pkg::insn_u           inst1,
    output logic                    tgt_valid,
    output logic                    tgt_slot,
    output logic [fe_pkg::pc_w-1:0] tgt_pc
);

    import fe_pkg::*;

    logic [1:0]        cls0;
    logic [1:0]        cls1;
    logic              sel0;
    logic              sel1;
    insn_u             sel_w;
    logic [1:0]        sel_cls;
    logic [pc_w-1:0]   slot_pc;
    logic [inst_w-1:0] offs;

    assign cls0 = branch_class(inst0);
    assign cls1 = branch_class(inst1);

    // only direct branches have a target here
    assign sel0 = !pc[2] && (cls0 == btype_uncond || cls0 == btype_pcrel);
    assign sel1 = (cls1 == btype_uncond || cls1 == btype_pcrel);

    assign tgt_valid = sel0 || sel1;
    assign tgt_slot  = !sel0 && sel1;

    assign sel_w   = sel0 ? inst0 : inst1;
    assign sel_cls = sel0 ? cls0 : cls1;

    // packet base, second slot sits 4 bytes up
    always_comb begin
        slot_pc = {pc[pc_w-1:3], 1'b0, pc[1:0]};
        if (!sel0) begin
            slot_pc = slot_pc + 32'd4;
        end
    end

    // b/bl carry offs26 split as hi10 below lo16
    always_comb begin
        if (sel_cls == btype_uncond) begin
            offs = {{4{sel_w.lbr.offs_hi10[9]}}, sel_w.lbr.offs_hi10,
                    sel_w.lbr.offs_lo16, 2'b00};
        end else begin
            offs = {{14{sel_w.fld.offs16[15]}}, sel_w.fld.offs16, 2'b00};
        end
    end

    assign tgt_pc = slot_pc + offs;

endmodule

// File: src/fe_pkg.sv
package fe_pkg;

    // fixed by the ISA
    localparam int inst_w = 32;
    localparam int pc_w   = 32;

    // packet branch type codes
    localparam logic [1:0] btype_none     = 2'b00;
    localparam logic [1:0] btype_uncond   = 2'b01;
    localparam logic [1:0] btype_pcrel    = 2'b10;
    localparam logic [1:0] btype_indirect = 2'b11;

    // major opcode groups
    localparam logic [4:0] op5_ibar_grp = 5'b00111;
    localparam logic [7:0] op8_csr      = 8'b00000100;
    localparam logic [4:0] op5_b        = 5'b01010;
    localparam logic [4:0] op5_bl       = 5'b01001;
    localparam logic [4:0] op5_beqz_grp = 5'b01011;
    localparam logic [3:0] op4_bcc      = 4'b0110;
    localparam logic [4:0] op5_jirl     = 5'b10011;

    // tlb maintenance words
    localparam logic [inst_w-1:0] tlb_srch_word = 32'b0000011_0010010000_01100_00000_00000;
    localparam logic [inst_w-1:0] tlb_rd_word   = 32'b0000011_0010010000_01101_00000_00000;
    localparam logic [16:0]       tlb_inv_prefix = 17'b0000011_0010010011;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [5:0]  op;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } fld;
        struct packed {
            logic [5:0]  op;
            logic [15:0] offs_lo16;
            logic [9:0]  offs_hi10;
        } lbr;
    } insn_u;

    // priority decode of the branch class of one slot
    function automatic logic [1:0] branch_class(insn_u w);
        if (w.fld.op[5:1] == op5_b || w.fld.op[5:1] == op5_bl) begin
            return btype_uncond;
        end else if (w.fld.op[5:1] == op5_beqz_grp || w.fld.op[5:2] == op4_bcc) begin
            return btype_pcrel;
        end else if (w.fld.op[5:1] == op5_jirl) begin
            return btype_indirect;
        end
        return btype_none;
    endfunction

endpackage

// File: src/if1_packet_reg.sv
`timescale 1ns/1ps

module if1_packet_reg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [fe_pkg::pc_w-1:0]   in_pc,
    input  logic [fe_pkg::inst_w-1:0] in_inst0,
    input  logic [fe_pkg::inst_w-1:0] in_inst1,
    input  logic                      stall,
    output logic                      s1_valid,
    output logic [fe_pkg::pc_w-1:0]   s1_pc,
    output logic [fe_pkg::inst_w-1:0] s1_inst0,
    output logic [fe_pkg::inst_w-1:0] s1_inst1
);

    // valid bit, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
        end
    end

    // packet payload
    // held as long as the fence is up
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_pc    <= in_pc;
            s1_inst0 <= in_inst0;
            s1_inst1 <= in_inst1;
        end
    end

endmodule

// File: src/pre_decoder.sv
`timescale 1ns/1ps

module pre_decoder (
    input  fe_pkg::insn_u           inst0,
    input  fe_pkg::insn_u           inst1,
    input  logic [fe_pkg::pc_w-1:0] pc,
    output logic [1:0]              priv_flag,
    output logic [1:0]              ibar_flag,
    output logic [1:0]              csr_flag,
    output logic [1:0]              tlb_flag,
    output logic [1:0]              branch_flag,
    output logic [1:0]              inst_btype
);

    import fe_pkg::*;

    insn_u      slot_w   [2];
    logic [1:0] slot_cls [2];

    assign slot_w[0] = inst0;
    assign slot_w[1] = inst1;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        logic [inst_w-1:0] word;
        logic [7:0]        op8;

        assign word = slot_w[i];
        assign op8  = word[31:24];

        // dbar/ibar share the group, bit 15 picks ibar
        assign ibar_flag[i] = (slot_w[i].fld.op[5:1] == op5_ibar_grp) && word[15];

        // csrrd uses rj == 0, only writes and exchanges count
        assign csr_flag[i] = (op8 == op8_csr) && (slot_w[i].fld.rj != 5'd0);

        assign tlb_flag[i] = (word == tlb_srch_word) ||
                             (word == tlb_rd_word) ||
                             (word[31:15] == tlb_inv_prefix);

        assign slot_cls[i]    = branch_class(slot_w[i]);
        assign branch_flag[i] = (slot_cls[i] != btype_none);
    end

    assign priv_flag = ibar_flag | csr_flag | tlb_flag;

    // packet branch type
    // slot 1 dominates, slot 0 only matters on an aligned pc
    always_comb begin
        if (slot_cls[1] != btype_none) begin
            inst_btype = slot_cls[1];
        end else if (pc[2]) begin
            inst_btype = btype_none;
        end else if (slot_cls[0] == btype_indirect) begin
            inst_btype = btype_indirect;
        end else begin
            inst_btype = btype_none;
        end
    end

endmodule

// File: src/predecode_top.sv
`timescale 1ns/1ps

module predecode_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic [fe_pkg::pc_w-1:0]   in_pc,
    input  logic [fe_pkg::inst_w-1:0] in_inst0,
    input  logic [fe_pkg::inst_w-1:0] in_inst1,
    input  logic                      priv_done,
    output logic                      out_valid,
    output logic [1:0]                out_priv_flag,
    output logic [1:0]                out_ibar_flag,
    output logic [1:0]                out_csr_flag,
    output logic [1:0]                out_tlb_flag,
    output logic [1:0]                out_branch_flag,
    output logic [1:0]                out_btype,
    output logic                      out_tgt_valid,
    output logic                      out_tgt_slot,
    output logic [fe_pkg::pc_w-1:0]   out_tgt_pc,
    output logic                      fetch_stall
);

    import fe_pkg::*;

    // stage 1 outputs
    logic              s1_valid;
    logic [pc_w-1:0]   s1_pc;
    logic [inst_w-1:0] s1_inst0;
    logic [inst_w-1:0] s1_inst1;

    // predecode results
    logic [1:0]        priv_flag;
    logic [1:0]        ibar_flag;
    logic [1:0]        csr_flag;
    logic [1:0]        tlb_flag;
    logic [1:0]        branch_flag;
    logic [1:0]        inst_btype;
    logic              tgt_valid;
    logic              tgt_slot;
    logic [pc_w-1:0]   tgt_pc;

    if1_packet_reg i_if1_packet_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_inst0 (in_inst0),
        .in_inst1 (in_inst1),
        .stall    (fetch_stall),
        .s1_valid (s1_valid),
        .s1_pc    (s1_pc),
        .s1_inst0 (s1_inst0),
        .s1_inst1 (s1_inst1)
    );

    pre_decoder i_pre_decoder (
        .inst0       (s1_inst0),
        .inst1       (s1_inst1),
        .pc          (s1_pc),
        .priv_flag   (priv_flag),
        .ibar_flag   (ibar_flag),
        .csr_flag    (csr_flag),
        .tlb_flag    (tlb_flag),
        .branch_flag (branch_flag),
        .inst_btype  (inst_btype)
    );

    branch_target i_branch_target (
        .pc        (s1_pc),
        .inst0     (s1_inst0),
        .inst1     (s1_inst1),
        .tgt_valid (tgt_valid),
        .tgt_slot  (tgt_slot),
        .tgt_pc    (tgt_pc)
    );

    priv_fence i_priv_fence (
        .clk             (clk),
        .rst_n           (rst_n),
        .s1_valid        (s1_valid),
        .priv_flag       (priv_flag),
        .ibar_flag       (ibar_flag),
        .csr_flag        (csr_flag),
        .tlb_flag        (tlb_flag),
        .branch_flag     (branch_flag),
        .inst_btype      (inst_btype),
        .tgt_valid       (tgt_valid),
        .tgt_slot        (tgt_slot),
        .tgt_pc          (tgt_pc),
        .priv_done       (priv_done),
        .out_valid       (out_valid),
        .out_priv_flag   (out_priv_flag),
        .out_ibar_flag   (out_ibar_flag),
        .out_csr_flag    (out_csr_flag),
        .out_tlb_flag    (out_tlb_flag),
        .out_branch_flag (out_branch_flag),
        .out_btype       (out_btype),
        .out_tgt_valid   (out_tgt_valid),
        .out_tgt_slot    (out_tgt_slot),
        .out_tgt_pc      (out_tgt_pc),
        .fetch_stall     (fetch_stall)
    );

endmodule

// File: src/priv_fence.sv
`timescale 1ns/1ps

module priv_fence (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    s1_valid,
    input  logic [1:0]              priv_flag,
    input  logic [1:0]              ibar_flag,
    input  logic [1:0]              csr_flag,
    input  logic [1:0]              tlb_flag,
    input  logic [1:0]              branch_flag,
    input  logic [1:0]              inst_btype,
    input  logic                    tgt_valid,
    input  logic                    tgt_slot,
    input  logic [fe_pkg::pc_w-1:0] tgt_pc,
    input  logic                    priv_done,
    output logic                    out_valid,
    output logic [1:0]              out_priv_flag,
    output logic [1:0]              out_ibar_flag,
    output logic [1:0]              out_csr_flag,
    output logic [1:0]              out_tlb_flag,
    output logic [1:0]              out_branch_flag,
    output logic [1:0]              out_btype,
    output logic                    out_tgt_valid,
    output logic                    out_tgt_slot,
    output logic [fe_pkg::pc_w-1:0] out_tgt_pc,
    output logic                    fetch_stall
);

    logic load;

    // nothing moves while fenced
    assign load = s1_valid && !fetch_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid       <= 1'b0;
            fetch_stall     <= 1'b0;
            out_priv_flag   <= 2'b00;
            out_ibar_flag   <= 2'b00;
            out_csr_flag    <= 2'b00;
            out_tlb_flag    <= 2'b00;
            out_branch_flag <= 2'b00;
            out_btype       <= 2'b00;
            out_tgt_valid   <= 1'b0;
            out_tgt_slot    <= 1'b0;
        end else begin
            out_valid <= load;
            if (load) begin
                out_priv_flag   <= priv_flag;
                out_ibar_flag   <= ibar_flag;
                out_csr_flag    <= csr_flag;
                out_tlb_flag    <= tlb_flag;
                out_branch_flag <= branch_flag;
                out_btype       <= inst_btype;
                out_tgt_valid   <= tgt_valid;
                out_tgt_slot    <= tgt_slot;
            end
            // fence goes up with the priv packet itself, drops after retire
            if (load && (priv_flag != 2'b00)) begin
                fetch_stall <= 1'b1;
            end else if (fetch_stall && priv_done) begin
                fetch_stall <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_tgt_pc <= tgt_pc;
        end
    end

endmodule

// File: verif/tb_predecode.sv
`timescale 1ns/1ps

module tb_predecode;

    localparam int rst_cycles = 5;
    localparam int n_directed = 19;
    localparam int n_random   = 200;
    // three cycles per packet covers the fences with room to spare
    localparam int max_cycles = rst_cycles + 3 * (n_directed + n_random);

    // branch classes and btype codes
    localparam logic [1:0] cls_none     = 2'b00;
    localparam logic [1:0] cls_uncond   = 2'b01;
    localparam logic [1:0] cls_pcrel    = 2'b10;
    localparam logic [1:0] cls_indirect = 2'b11;

    // opcode fields for directed words
    localparam logic [4:0]  op_ibar  = 5'b00111;
    localparam logic [7:0]  op_csr   = 8'b00000100;
    localparam logic [4:0]  op_b     = 5'b01010;
    localparam logic [4:0]  op_bl    = 5'b01001;
    localparam logic [4:0]  op_beqz  = 5'b01011;
    localparam logic [3:0]  op_bcc4  = 4'b0110;
    localparam logic [4:0]  op_jirl  = 5'b10011;
    localparam logic [31:0] tlb_srch = 32'b0000011_0010010000_01100_00000_00000;
    localparam logic [31:0] tlb_rd   = 32'b0000011_0010010000_01101_00000_00000;
    localparam logic [16:0] tlb_inv  = 17'b0000011_0010010011;
    localparam logic [31:0] nop_word = 32'h0340_0000;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_pc;
    logic [31:0] in_inst0;
    logic [31:0] in_inst1;
    logic        priv_done;
    logic        out_valid;
    logic [1:0]  out_priv_flag;
    logic [1:0]  out_ibar_flag;
    logic [1:0]  out_csr_flag;
    logic [1:0]  out_tlb_flag;
    logic [1:0]  out_branch_flag;
    logic [1:0]  out_btype;
    logic        out_tgt_valid;
    logic        out_tgt_slot;
    logic [31:0] out_tgt_pc;
    logic        fetch_stall;

    // reference pipeline state
    logic        m1_valid;
    logic [31:0] m1_pc;
    logic [31:0] m1_i0;
    logic [31:0] m1_i1;
    logic [1:0]  m_priv;
    logic        m_stall;
    logic        exp_valid;
    logic [1:0]  exp_priv;
    logic [1:0]  exp_ibar;
    logic [1:0]  exp_csr;
    logic [1:0]  exp_tlb;
    logic [1:0]  exp_branch;
    logic [1:0]  exp_btype;
    logic        exp_tgt_valid;
    logic        exp_tgt_slot;
    logic [31:0] exp_tgt_pc;

    logic        stall_seen;
    int          wait_cnt;
    int          errors;
    int          cycles;
    logic [31:0] lcg_state;

    predecode_top i_dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_pc           (in_pc),
        .in_inst0        (in_inst0),
        .in_inst1        (in_inst1),
        .priv_done       (priv_done),
        .out_valid       (out_valid),
        .out_priv_flag   (out_priv_flag),
        .out_ibar_flag   (out_ibar_flag),
        .out_csr_flag    (out_csr_flag),
        .out_tlb_flag    (out_tlb_flag),
        .out_branch_flag (out_branch_flag),
        .out_btype       (out_btype),
        .out_tgt_valid   (out_tgt_valid),
        .out_tgt_slot    (out_tgt_slot),
        .out_tgt_pc      (out_tgt_pc),
        .fetch_stall     (fetch_stall)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [1:0] slot_class(input logic [31:0] w);
        if (w[31:27] == op_b || w[31:27] == op_bl) return cls_uncond;
        if (w[31:27] == op_beqz || w[31:28] == op_bcc4) return cls_pcrel;
        if (w[31:27] == op_jirl) return cls_indirect;
        return cls_none;
    endfunction

    function automatic logic ibar_hit(input logic [31:0] w);
        return (w[31:27] == op_ibar) && w[15];
    endfunction

    function automatic logic csr_hit(input logic [31:0] w);
        return (w[31:24] == op_csr) && (w[9:5] != 5'd0);
    endfunction

    function automatic logic tlb_hit(input logic [31:0] w);
        return (w == tlb_srch) || (w == tlb_rd) || (w[31:15] == tlb_inv);
    endfunction

    function automatic logic priv_hit(input logic [31:0] w);
        return ibar_hit(w) || csr_hit(w) || tlb_hit(w);
    endfunction

    function automatic logic [1:0] packet_btype(input logic [31:0] pc, input logic [31:0] w0,
                                                input logic [31:0] w1);
        if (slot_class(w1) != cls_none) return slot_class(w1);
        if (pc[2]) return cls_none;
        if (slot_class(w0) == cls_indirect) return cls_indirect;
        return cls_none;
    endfunction

    // {valid, slot, target}
    function automatic logic [33:0] direct_target(input logic [31:0] pc, input logic [31:0] w0,
                                                  input logic [31:0] w1);
        logic [1:0]  c0;
        logic [1:0]  c1;
        logic        use0;
        logic        use1;
        logic [31:0] w;
        logic [31:0] base;
        logic [31:0] offs;
        c0 = slot_class(w0);
        c1 = slot_class(w1);
        use0 = !pc[2] && (c0 == cls_uncond || c0 == cls_pcrel);
        use1 = (c1 == cls_uncond || c1 == cls_pcrel);
        if (!use0 && !use1) return 34'd0;
        w = use0 ? w0 : w1;
        base = (pc & ~32'd4) + (use0 ? 32'd0 : 32'd4);
        if ((use0 ? c0 : c1) == cls_uncond) begin
            offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        end else begin
            offs = {{14{w[25]}}, w[25:10], 2'b00};
        end
        return {1'b1, !use0, base + offs};
    endfunction

    function automatic logic [31:0] long_br(input logic [4:0] op5, input logic [25:0] offs);
        return {op5, 1'b0, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] short_br(input logic [4:0] op5, input logic [15:0] offs);
        return {op5, 1'b0, offs, 5'd7, 5'd3};
    endfunction

    // random slot word biased toward branches
    function automatic logic [31:0] shape_word(input logic [31:0] r, input logic [3:0] sel);
        case (sel)
            4'd0: return {op_b, r[26:0]};
            4'd1: return {op_bl, r[26:0]};
            4'd2: return {op_beqz, r[26:0]};
            4'd3: return {op_bcc4, r[27:0]};
            4'd4: return {op_jirl, r[26:0]};
            default: return r;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        $display("CHECK FAILED %s: expected 0x%0h, got 0x%0h at %0t", name, expv, actv, $time);
        errors++;
    endtask

    task automatic note_fault(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    // present a packet and keep it there until an edge accepts it
    task automatic send_packet(input logic [31:0] pc, input logic [31:0] w0,
                               input logic [31:0] w1);
        @(posedge clk);
        in_valid <= 1'b1;
        in_pc    <= pc;
        in_inst0 <= w0;
        in_inst1 <= w1;
        @(negedge clk);
        while (fetch_stall) @(negedge clk);
    endtask

    task automatic drive_directed();
        // csr read and dbar are not privileged
        send_packet(32'h0000_1000, {op_csr, 14'h0a5, 5'd0, 5'd4}, {op_ibar, 11'd0, 1'b0, 15'h11});
        // ibar fences while the next packet waits in stage 1
        send_packet(32'h0000_1008, {op_ibar, 11'd0, 1'b1, 15'd0}, nop_word);
        send_packet(32'h0000_1010, long_br(op_b, 26'h40), {op_jirl, 27'h0123});
        send_packet(32'h0000_1018, nop_word, {op_csr, 14'h0a5, 5'd5, 5'd4});
        send_packet(32'h0000_1020, tlb_srch, nop_word);
        send_packet(32'h0000_1028, nop_word, tlb_rd);
        send_packet(32'h0000_1030, {tlb_inv, 15'h0123}, nop_word);
        // csr write in slot 0 and ibar in slot 1
        send_packet(32'h0000_1038, {op_csr, 14'h0a5, 5'd5, 5'd4}, {op_ibar, 11'd0, 1'b1, 15'd0});
        // btype rule corners
        send_packet(32'h0000_1004, {op_jirl, 27'h55}, nop_word);
        send_packet(32'h0000_2000, {op_jirl, 27'h55}, nop_word);
        send_packet(32'h0000_2008, long_br(op_b, 26'h100), nop_word);
        send_packet(32'h0000_200c, long_br(op_b, 26'h100), short_br({op_bcc4, 1'b1}, 16'h0020));
        // targets with both offset signs in each slot
        send_packet(32'h0000_3000, long_br(op_bl, 26'h3ff_ff00), nop_word);
        send_packet(32'h0000_3104, nop_word, long_br(op_bl, 26'h3ff_fff0));
        send_packet(32'h0000_4000, short_br(op_beqz, 16'hfff0), {op_jirl, 27'h1});
        send_packet(32'h0000_4008, nop_word, short_br({op_bcc4, 1'b0}, 16'h0123));
        send_packet(32'h0000_400c, short_br(op_beqz, 16'h0040), short_br(op_beqz, 16'h8000));
        send_packet(32'h0000_5000, long_br(op_b, 26'h0ab_cdef), long_br(op_bl, 26'h200_0004));
        send_packet(32'h0000_5008, {op_jirl, 27'h2}, {op_jirl, 27'h3});
    endtask

    task automatic stream_random();
        logic [31:0] sel;
        logic [31:0] pc;
        logic [31:0] w0;
        logic [31:0] w1;
        for (int k = 0; k < n_random; k++) begin
            sel = next_rand();
            pc  = {next_rand() & 32'hffff_fffc};
            w0  = shape_word(next_rand(), sel[31:28]);
            w1  = shape_word(next_rand(), sel[27:24]);
            send_packet(pc, w0, w1);
        end
    endtask

    // back end retires the privileged instruction a few cycles into the fence
    always @(negedge clk) stall_seen <= fetch_stall;

    always @(posedge clk) begin
        if (!rst_n || !stall_seen) begin
            wait_cnt  <= 0;
            priv_done <= 1'b0;
        end else begin
            wait_cnt  <= wait_cnt + 1;
            priv_done <= (wait_cnt == 2);
        end
    end

    // reference pipeline with stage 1 and the fence
    assign m_priv = {priv_hit(m1_i1), priv_hit(m1_i0)};

    always @(posedge clk) begin
        if (!rst_n) begin
            m1_valid  <= 1'b0;
            m_stall   <= 1'b0;
            exp_valid <= 1'b0;
        end else begin
            exp_valid <= m1_valid && !m_stall;
            if (m1_valid && !m_stall) begin
                exp_priv   <= m_priv;
                exp_ibar   <= {ibar_hit(m1_i1), ibar_hit(m1_i0)};
                exp_csr    <= {csr_hit(m1_i1), csr_hit(m1_i0)};
                exp_tlb    <= {tlb_hit(m1_i1), tlb_hit(m1_i0)};
                exp_branch <= {slot_class(m1_i1) != cls_none, slot_class(m1_i0) != cls_none};
                exp_btype  <= packet_btype(m1_pc, m1_i0, m1_i1);
                {exp_tgt_valid, exp_tgt_slot, exp_tgt_pc} <= direct_target(m1_pc, m1_i0, m1_i1);
            end
            if (m1_valid && !m_stall && m_priv != 2'b00) begin
                m_stall <= 1'b1;
            end else if (m_stall && priv_done) begin
                m_stall <= 1'b0;
            end
            if (!m_stall) begin
                m1_valid <= in_valid;
                m1_pc    <= in_pc;
                m1_i0    <= in_inst0;
                m1_i1    <= in_inst1;
            end
        end
    end

    assert property (@(posedge clk) !rst_n |=> (!out_valid && !fetch_stall && !out_tgt_valid
            && out_priv_flag == 2'b00 && out_ibar_flag == 2'b00 && out_csr_flag == 2'b00
            && out_tlb_flag == 2'b00 && out_branch_flag == 2'b00 && out_btype == 2'b00))
        else note_fault("outputs not cleared during or right after reset");

    assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
        else report_mismatch("out_valid", 32'($sampled(exp_valid)), 32'($sampled(out_valid)));
    assert property (@(posedge clk) disable iff (!rst_n) fetch_stall == m_stall)
        else report_mismatch("fetch_stall", 32'($sampled(m_stall)), 32'($sampled(fetch_stall)));
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_priv_flag == exp_priv)
        else report_mismatch("out_priv_flag", 32'($sampled(exp_priv)),
                             32'($sampled(out_priv_flag)));
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_ibar_flag == exp_ibar)
        else report_mismatch("out_ibar_flag", 32'($sampled(exp_ibar)),
                             32'($sampled(out_ibar_flag)));
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_csr_flag == exp_csr)
        else report_mismatch("out_csr_flag", 32'($sampled(exp_csr)), 32'($sampled(out_csr_flag)));
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_tlb_flag == exp_tlb)
        else report_mismatch("out_tlb_flag", 32'($sampled(exp_tlb)), 32'($sampled(out_tlb_flag)));
    assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> out_branch_flag == exp_branch)
        else report_mismatch("out_branch_flag", 32'($sampled(exp_branch)),
                             32'($sampled(out_branch_flag)));
    assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> out_btype == exp_btype)
        else report_mismatch("out_btype", 32'($sampled(exp_btype)), 32'($sampled(out_btype)));
    assert property (@(posedge clk) disable iff (!rst_n)
            out_valid |-> out_tgt_valid == exp_tgt_valid)
        else report_mismatch("out_tgt_valid", 32'($sampled(exp_tgt_valid)),
                             32'($sampled(out_tgt_valid)));
    // slot and target only mean something for a direct branch
    assert property (@(posedge clk) disable iff (!rst_n)
            (out_valid && exp_tgt_valid) |-> out_tgt_slot == exp_tgt_slot)
        else report_mismatch("out_tgt_slot", 32'($sampled(exp_tgt_slot)),
                             32'($sampled(out_tgt_slot)));
    assert property (@(posedge clk) disable iff (!rst_n)
            (out_valid && exp_tgt_valid) |-> out_tgt_pc == exp_tgt_pc)
        else report_mismatch("out_tgt_pc", $sampled(exp_tgt_pc), $sampled(out_tgt_pc));

    assert property (@(posedge clk) disable iff (!rst_n)
            $rose(fetch_stall) |-> (out_valid && out_priv_flag != 2'b00))
        else note_fault("fetch_stall rose without a privileged packet at the output");
    assert property (@(posedge clk) disable iff (!rst_n) fetch_stall |=> !out_valid)
        else note_fault("out_valid seen while the fence was up");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("errors: %0d", errors);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pc     = 32'd0;
        in_inst0  = 32'd0;
        in_inst1  = 32'd0;
        priv_done = 1'b0;
        lcg_state = 32'h7ab404d2;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
        drive_directed();
        stream_random();
        @(posedge clk);
        in_valid <= 1'b0;
        // drain whatever is still in flight
        @(negedge clk);
        while (fetch_stall || m1_valid || out_valid || exp_valid) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
